// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_periph_subsystem \
		-f project.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: apb_periph_decode.sv
// APB region decoder: selects the timer or the UART and returns the selected response
module apb_periph_decode (
	input  logic                              psel,
	input  periph_pkg::apb_addr_t             paddr,

	// Timer response
	input  logic [periph_pkg::APB_DATA_W-1:0] timer_prdata,
	input  logic                              timer_pready,
	input  logic                              timer_pslverr,

	// UART response
	input  logic [periph_pkg::APB_DATA_W-1:0] uart_prdata,
	input  logic                              uart_pready,
	input  logic                              uart_pslverr,

	// Peripheral selects
	output logic                              timer_sel,
	output logic                              uart_sel,

	// Response towards the bus master
	output logic [periph_pkg::APB_DATA_W-1:0] prdata,
	output logic                              pready,
	output logic                              pslverr
);

	logic hit_timer;
	logic hit_uart;

	// ------------------------------
	// Region decode

	assign hit_timer = paddr.fields.region == periph_pkg::REGION_TIMER;
	assign hit_uart  = paddr.fields.region == periph_pkg::REGION_UART;

	assign timer_sel = psel && hit_timer;
	assign uart_sel  = psel && hit_uart;

	// ------------------------------
	// Response mux

	always_comb begin
		if (hit_timer) begin
			prdata  = timer_prdata;
			pready  = timer_pready;
			pslverr = timer_pslverr;
		end else if (hit_uart) begin
			prdata  = uart_prdata;
			pready  = uart_pready;
			pslverr = uart_pslverr;
		end else begin
			// Unmapped region, answered here without a peripheral
			prdata  = '0;
			pready  = 1'b1;
			pslverr = psel;
		end
	end

endmodule

// File: mtimer.sv
// Machine timer on APB: microsecond prescaler, 64-bit mtime/mtimecmp and timer interrupt
module mtimer (
	input  logic                              clk,
	input  logic                              rst_n,

	// APB slave port
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  periph_pkg::apb_addr_t             paddr,
	input  logic [periph_pkg::APB_DATA_W-1:0] pwdata,
	output logic [periph_pkg::APB_DATA_W-1:0] prdata,
	output logic                              pready,
	output logic                              pslverr,

	// Freezes mtime while high
	input  logic                              dbg_halt,

	output logic                              timer_irq
);

	logic [$clog2(periph_pkg::CLK_MHZ)-1:0] tick_ctr;
	logic                                   tick;

	logic                                   ctrl_en;
	logic [2*periph_pkg::APB_DATA_W-1:0]    mtime;
	logic [2*periph_pkg::APB_DATA_W-1:0]    mtimecmp;

	logic                                   acc;
	logic                                   wr;
	logic                                   offset_ok;

	// ------------------------------
	// Microsecond prescaler

	// Free-running from reset, tick on every pass through zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= $bits(tick_ctr)'(periph_pkg::CLK_MHZ - 1);
		end else if (tick) begin
			tick_ctr <= $bits(tick_ctr)'(periph_pkg::CLK_MHZ - 1);
		end else begin
			tick_ctr <= tick_ctr - 1'b1;
		end
	end

	assign tick = ~|tick_ctr;

	// ------------------------------
	// APB access decode

	assign acc = psel && penable;
	assign wr  = acc && pwrite && offset_ok;

	always_comb begin
		case (paddr.fields.offset)
			periph_pkg::TMR_CTRL,
			periph_pkg::TMR_MTIME_LO,
			periph_pkg::TMR_MTIME_HI,
			periph_pkg::TMR_CMP_LO,
			periph_pkg::TMR_CMP_HI: offset_ok = 1'b1;
			default:                offset_ok = 1'b0;
		endcase
	end

	// Never stalls
	assign pready  = 1'b1;
	assign pslverr = acc && !offset_ok;

	// ------------------------------
	// Registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en  <= 1'b0;
			mtimecmp <= '1;
		end else if (wr) begin
			case (paddr.fields.offset)
				periph_pkg::TMR_CTRL:   ctrl_en         <= pwdata[0];
				periph_pkg::TMR_CMP_LO: mtimecmp[31:0]  <= pwdata;
				periph_pkg::TMR_CMP_HI: mtimecmp[63:32] <= pwdata;
				default: ;
			endcase
		end
	end

	// Software writes win over the tick increment
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (wr && paddr.fields.offset == periph_pkg::TMR_MTIME_LO) begin
			mtime[31:0] <= pwdata;
		end else if (wr && paddr.fields.offset == periph_pkg::TMR_MTIME_HI) begin
			mtime[63:32] <= pwdata;
		end else if (tick && ctrl_en && !dbg_halt) begin
			mtime <= mtime + 1'b1;
		end
	end

	// Level interrupt, one cycle behind the registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= mtime >= mtimecmp;
		end
	end

	// ------------------------------
	// Read data, zero outside a read access

	always_comb begin
		prdata = '0;
		if (acc && !pwrite) begin
			case (paddr.fields.offset)
				periph_pkg::TMR_CTRL:     prdata[0] = ctrl_en;
				periph_pkg::TMR_MTIME_LO: prdata    = mtime[31:0];
				periph_pkg::TMR_MTIME_HI: prdata    = mtime[63:32];
				periph_pkg::TMR_CMP_LO:   prdata    = mtimecmp[31:0];
				periph_pkg::TMR_CMP_HI:   prdata    = mtimecmp[63:32];
				default: ;
			endcase
		end
	end

endmodule

// File: periph_pkg.sv
// Shared constants, register map and APB address layout, referenced by scoped names
package periph_pkg;

	// Bus widths
	localparam int APB_DATA_W = 32;
	localparam int APB_ADDR_W = 16;

	// Clock cycles per microsecond timer tick
	localparam int CLK_MHZ = 12;

	// ------------------------------
	// Address regions, selected by paddr[15:14]
	// Regions 2 and 3 are unmapped
	localparam logic [1:0] REGION_TIMER = 2'd0;
	localparam logic [1:0] REGION_UART  = 2'd1;

	// ------------------------------
	// Timer register offsets
	localparam logic [7:0] TMR_CTRL     = 8'h00;
	localparam logic [7:0] TMR_MTIME_LO = 8'h08;
	localparam logic [7:0] TMR_MTIME_HI = 8'h0c;
	localparam logic [7:0] TMR_CMP_LO   = 8'h10;
	localparam logic [7:0] TMR_CMP_HI   = 8'h14;

	// ------------------------------
	// UART register offsets
	localparam logic [7:0] UART_TXDATA = 8'h00;
	localparam logic [7:0] UART_STATUS = 8'h04;
	localparam logic [7:0] UART_DIV    = 8'h08;

	// Clocks per bit, register width and value out of reset
	localparam int              UART_DIV_W     = 16;
	localparam logic [15:0]     UART_DIV_RESET = 16'd16;

	// Start bit, 8 data bits, stop bit
	localparam int UART_FRAME_BITS = 10;

	// One APB address word, seen either whole or split into region and offset
	typedef union packed {
		logic [APB_ADDR_W-1:0] raw;
		struct packed {
			logic [1:0] region;
			logic [5:0] unused;
			logic [7:0] offset;
		} fields;
	} apb_addr_t;

endpackage

// File: periph_props.sv
// Concurrent APB and UART line checks, bound into the peripheral subsystem top
module periph_props (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  psel,
	input logic                  penable,
	input periph_pkg::apb_addr_t paddr,
	input logic                  pready,
	input logic                  pslverr,
	input logic                  uart_tx
);

	int fail_count = 0;

	// Setup phase moves on to an access phase for the same address
	setup_then_access: assert property (
		@(posedge clk) disable iff (!rst_n)
		psel && !penable |=> psel && penable && $stable(paddr.raw)
	) else begin
		$error("APB setup cycle not followed by an access cycle to the same address");
		fail_count++;
	end

	err_with_ready: assert property (
		@(posedge clk) disable iff (!rst_n)
		pslverr |-> pready
	) else begin
		$error("pslverr high while pready is low");
		fail_count++;
	end

	// Line idles high while held in reset
	tx_idle_in_reset: assert property (
		@(posedge clk)
		!rst_n |-> uart_tx
	) else begin
		$error("uart_tx low during reset");
		fail_count++;
	end

endmodule

// File: periph_subsystem.sv
// Peripheral subsystem top: external APB port decoded onto the machine timer and UART TX
module periph_subsystem (
	input  logic                              clk,
	input  logic                              rst_n,

	// External APB port
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  periph_pkg::apb_addr_t             paddr,
	input  logic [periph_pkg::APB_DATA_W-1:0] pwdata,
	output logic [periph_pkg::APB_DATA_W-1:0] prdata,
	output logic                              pready,
	output logic                              pslverr,

	// Debug freeze for the timer
	input  logic                              dbg_halt,

	output logic                              timer_irq,
	output logic                              uart_tx
);

	logic                              timer_sel;
	logic [periph_pkg::APB_DATA_W-1:0] timer_prdata;
	logic                              timer_pready;
	logic                              timer_pslverr;

	logic                              uart_sel;
	logic [periph_pkg::APB_DATA_W-1:0] uart_prdata;
	logic                              uart_pready;
	logic                              uart_pslverr;

	// ------------------------------
	// Region decode

	apb_periph_decode u_decode (
		.psel          (psel),
		.paddr         (paddr),
		.timer_prdata  (timer_prdata),
		.timer_pready  (timer_pready),
		.timer_pslverr (timer_pslverr),
		.uart_prdata   (uart_prdata),
		.uart_pready   (uart_pready),
		.uart_pslverr  (uart_pslverr),
		.timer_sel     (timer_sel),
		.uart_sel      (uart_sel),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr)
	);

	// ------------------------------
	// Peripherals

	mtimer u_mtimer (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (timer_sel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (timer_prdata),
		.pready    (timer_pready),
		.pslverr   (timer_pslverr),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	uart_tx u_uart_tx (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (uart_sel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (uart_prdata),
		.pready  (uart_pready),
		.pslverr (uart_pslverr),
		.tx      (uart_tx)
	);

endmodule

// File: project.f
periph_pkg.sv
apb_periph_decode.sv
mtimer.sv
uart_tx.sv
periph_subsystem.sv
periph_props.sv
tb_periph_subsystem.sv

// File: tb_periph_subsystem.sv
// Directed testbench for the peripheral subsystem, run from project.f with Verilator
module tb_periph_subsystem;

	localparam int CLK_PERIOD      = 40;
	localparam int TX_DIV          = 8;
	localparam int IRQ_K           = 5;
	localparam int WATCHDOG_CYCLES = 6 * 10 * TX_DIV + 300 * periph_pkg::CLK_MHZ;

	logic                  clk;
	logic                  rst_n;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	periph_pkg::apb_addr_t paddr;
	logic [31:0]           pwdata;
	logic [31:0]           prdata;
	logic                  pready;
	logic                  pslverr;
	logic                  dbg_halt;
	logic                  timer_irq;
	logic                  uart_tx;

	logic [31:0]           rng_state;
	int                    cycle = 0;
	int                    done_cycle;

	periph_subsystem u_periph_subsystem (.*);

	bind periph_subsystem periph_props u_props (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.paddr   (paddr),
		.pready  (pready),
		.pslverr (pslverr),
		.uart_tx (uart_tx)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$fatal(1, "Watchdog expired");
	end

	// ------------------------------
	// Checking and stimulus helpers

	task automatic fail_run();
		$display("TB FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_true(input string what, input logic cond);
		assert (cond === 1'b1) else begin
			$display("FAILED at %0t: %s", $time, what);
			fail_run();
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Called at 2 units after a rising edge, returns at the same point
	task automatic apb_access(input logic write, input logic [1:0] region,
			input logic [7:0] offset, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		logic done;
		psel                = 1'b1;
		penable             = 1'b0;
		pwrite              = write;
		paddr.fields.region = region;
		paddr.fields.unused = '0;
		paddr.fields.offset = offset;
		pwdata              = wdata;
		@(posedge clk);
		#2 penable = 1'b1;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			done  = pready;
			rdata = prdata;
			err   = pslverr;
			@(posedge clk);
			#2;
		end
		done_cycle = cycle;
		psel       = 1'b0;
		penable    = 1'b0;
	endtask

	task automatic apb_write(input logic [1:0] region, input logic [7:0] offset,
			input logic [31:0] data, output logic err);
		logic [31:0] ignored;
		apb_access(1'b1, region, offset, data, ignored, err);
	endtask

	task automatic apb_read(input logic [1:0] region, input logic [7:0] offset,
			output logic [31:0] data, output logic err);
		apb_access(1'b0, region, offset, '0, data, err);
	endtask

	task automatic write_reg(input logic [1:0] region, input logic [7:0] offset,
			input logic [31:0] data);
		logic err;
		apb_write(region, offset, data, err);
		check_true("register write answered with pslverr", err === 1'b0);
	endtask

	task automatic expect_reg(input logic [1:0] region, input logic [7:0] offset,
			input logic [31:0] exp, input string what);
		logic [31:0] data;
		logic        err;
		apb_read(region, offset, data, err);
		check_true({what, " read answered with pslverr"}, err === 1'b0);
		check_equal(what, data, exp);
	endtask

	// Samples the line at the middle of each bit
	task automatic uart_capture(input int div, output logic [7:0] data, output time t_start);
		logic [9:0] bits;
		@(negedge uart_tx);
		t_start = $time;
		repeat (div / 2) @(posedge clk);
		for (int i = 0; i < 10; i++) begin
			if (i > 0) repeat (div) @(posedge clk);
			@(negedge clk);
			bits[i] = uart_tx;
		end
		check_true("UART start bit is not low", bits[0] === 1'b0);
		check_true("UART stop bit is not high", bits[9] === 1'b1);
		data = bits[8:1];
	endtask

	// ------------------------------
	// Directed tests

	task automatic reset_defaults();
		check_true("uart_tx is not high after reset", uart_tx === 1'b1);
		check_true("timer_irq is not low after reset", timer_irq === 1'b0);
		expect_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CTRL, 0, "TMR_CTRL");
		expect_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CMP_LO, '1, "TMR_CMP_LO");
		expect_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CMP_HI, '1, "TMR_CMP_HI");
		expect_reg(periph_pkg::REGION_UART, periph_pkg::UART_STATUS, 0, "UART_STATUS");
		expect_reg(periph_pkg::REGION_UART, periph_pkg::UART_DIV,
			32'(periph_pkg::UART_DIV_RESET), "UART_DIV");
	endtask

	task automatic register_readback();
		logic [31:0] v [4];
		logic [31:0] data;
		logic        err;
		for (int i = 0; i < 4; i++) begin
			rng_state = xorshift32(rng_state);
			v[i] = rng_state;
		end
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_MTIME_LO, v[0]);
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_MTIME_HI, v[1]);
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CMP_LO, v[2]);
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CMP_HI, v[3]);
		write_reg(periph_pkg::REGION_UART, periph_pkg::UART_DIV, {16'b0, v[0][15:0]});
		// Unmapped regions and offsets
		apb_write(2'd2, periph_pkg::TMR_MTIME_LO, ~v[0], err);
		check_true("region 2 write did not return pslverr", err === 1'b1);
		apb_read(2'd3, periph_pkg::UART_DIV, data, err);
		check_true("region 3 read did not return pslverr", err === 1'b1);
		check_equal("region 3 read data", data, 0);
		apb_write(periph_pkg::REGION_TIMER, 8'h20, '1, err);
		check_true("timer offset 0x20 did not return pslverr", err === 1'b1);
		apb_write(periph_pkg::REGION_UART, 8'h0c, ~v[0], err);
		check_true("UART offset 0x0c did not return pslverr", err === 1'b1);
		expect_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CTRL, 0, "TMR_CTRL");
		expect_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_MTIME_LO, v[0], "mtime low");
		expect_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_MTIME_HI, v[1], "mtime high");
		expect_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CMP_LO, v[2], "mtimecmp low");
		expect_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CMP_HI, v[3], "mtimecmp high");
		expect_reg(periph_pkg::REGION_UART, periph_pkg::UART_DIV, {16'b0, v[0][15:0]},
			"UART_DIV");
	endtask

	task automatic mtime_counting();
		logic [31:0] data;
		logic        err;
		int          exp;
		exp = 600 / periph_pkg::CLK_MHZ;
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_MTIME_HI, 0);
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_MTIME_LO, 0);
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CTRL, 1);
		repeat (600) @(posedge clk);
		#2 write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CTRL, 0);
		apb_read(periph_pkg::REGION_TIMER, periph_pkg::TMR_MTIME_LO, data, err);
		check_true($sformatf("mtime advanced by %0d, expected %0d within one", data, exp),
			int'(data) >= exp - 1 && int'(data) <= exp + 1);
		// Frozen by debug halt, then by the enable bit
		dbg_halt = 1'b1;
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CTRL, 1);
		repeat (20 * periph_pkg::CLK_MHZ) @(posedge clk);
		#2 expect_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_MTIME_LO, data, "halted mtime");
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CTRL, 0);
		dbg_halt = 1'b0;
		repeat (20 * periph_pkg::CLK_MHZ) @(posedge clk);
		#2 expect_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_MTIME_LO, data, "disabled mtime");
	endtask

	task automatic irq_timing();
		int n;
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CMP_HI, '1);
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_MTIME_LO, 0);
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_MTIME_HI, 0);
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CMP_LO, IRQ_K);
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CMP_HI, 0);
		check_true("timer_irq high before the timer is enabled", timer_irq === 1'b0);
		write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CTRL, 1);
		n = 0;
		while (timer_irq !== 1'b1 && n <= (IRQ_K + 1) * periph_pkg::CLK_MHZ + 2) begin
			@(negedge clk);
			n++;
		end
		check_true($sformatf("timer_irq rose after %0d cycles, outside the window", n),
			timer_irq === 1'b1 && n >= (IRQ_K - 1) * periph_pkg::CLK_MHZ);
		@(posedge clk);
		#2 write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CMP_HI, 1);
		n = 0;
		while (timer_irq !== 1'b0 && n < 2) begin
			@(negedge clk);
			n++;
		end
		check_true("timer_irq did not drop within two cycles", timer_irq === 1'b0);
		@(posedge clk);
		#2 write_reg(periph_pkg::REGION_TIMER, periph_pkg::TMR_CTRL, 0);
	endtask

	task automatic frame_transmit();
		logic [7:0] got;
		time        t_start;
		write_reg(periph_pkg::REGION_UART, periph_pkg::UART_DIV, TX_DIV);
		repeat (3) begin
			rng_state = xorshift32(rng_state);
			fork
				uart_capture(TX_DIV, got, t_start);
				begin
					write_reg(periph_pkg::REGION_UART, periph_pkg::UART_TXDATA, rng_state);
					expect_reg(periph_pkg::REGION_UART, periph_pkg::UART_STATUS, 1, "busy");
				end
			join
			check_equal("UART byte", {24'b0, got}, {24'b0, rng_state[7:0]});
			repeat (TX_DIV) @(posedge clk);
			#2 expect_reg(periph_pkg::REGION_UART, periph_pkg::UART_STATUS, 0, "idle busy");
		end
	endtask

	task automatic write_backpressure();
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] c1;
		logic [7:0] c2;
		time        t1;
		time        t2;
		int         first_done;
		rng_state = xorshift32(rng_state);
		b1 = rng_state[7:0];
		rng_state = xorshift32(rng_state);
		b2 = rng_state[7:0];
		fork
			begin
				uart_capture(TX_DIV, c1, t1);
				uart_capture(TX_DIV, c2, t2);
			end
			begin
				write_reg(periph_pkg::REGION_UART, periph_pkg::UART_TXDATA, {24'b0, b1});
				first_done = done_cycle;
				write_reg(periph_pkg::REGION_UART, periph_pkg::UART_TXDATA, {24'b0, b2});
				check_true("second TXDATA write completed before the first frame ended",
					done_cycle - first_done >= 10 * TX_DIV);
			end
		join
		check_equal("first stalled byte", {24'b0, c1}, {24'b0, b1});
		check_equal("second stalled byte", {24'b0, c2}, {24'b0, b2});
		check_true("gap between back to back frames",
			t2 - t1 == time'(10 * TX_DIV * CLK_PERIOD));
	endtask

	// ------------------------------
	// Main sequence

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b1;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		dbg_halt  = 1'b0;
		rng_state = 32'he2b705df;
		// Falling edge applies the asynchronous reset before the first clock
		#1 rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#2 rst_n = 1'b1;
		reset_defaults();
		register_readback();
		mtime_counting();
		irq_timing();
		frame_transmit();
		write_backpressure();
		if (u_periph_subsystem.u_props.fail_count == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			fail_run();
		end
	end

endmodule

// File: uart_tx.sv
// UART transmitter on APB: sends 8N1 frames and holds off TXDATA writes while busy
module uart_tx (
	input  logic                              clk,
	input  logic                              rst_n,

	// APB slave port
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  periph_pkg::apb_addr_t             paddr,
	input  logic [periph_pkg::APB_DATA_W-1:0] pwdata,
	output logic [periph_pkg::APB_DATA_W-1:0] prdata,
	output logic                              pready,
	output logic                              pslverr,

	// Serial line, high when idle
	output logic                              tx
);

	logic [periph_pkg::UART_DIV_W-1:0]      div;
	logic [periph_pkg::UART_DIV_W-1:0]      bit_ctr;
	logic [3:0]                             bit_idx;
	logic [periph_pkg::UART_FRAME_BITS-1:0] shreg;
	logic                                   busy;

	logic                                   acc;
	logic                                   offset_ok;
	logic                                   txdata_wr;
	logic                                   bit_end;
	logic                                   frame_end;
	logic                                   tx_accept;

	// ------------------------------
	// APB access decode

	assign acc = psel && penable;

	always_comb begin
		case (paddr.fields.offset)
			periph_pkg::UART_TXDATA,
			periph_pkg::UART_STATUS,
			periph_pkg::UART_DIV: offset_ok = 1'b1;
			default:              offset_ok = 1'b0;
		endcase
	end

	assign txdata_wr = acc && pwrite && paddr.fields.offset == periph_pkg::UART_TXDATA;

	// Bit timing
	assign bit_end   = busy && bit_ctr == '0;
	assign frame_end = bit_end && bit_idx == 4'(periph_pkg::UART_FRAME_BITS - 1);

	// A busy write waits for the last cycle of the stop bit
	assign pready    = !(txdata_wr && busy && !frame_end);
	assign tx_accept = txdata_wr && pready;
	assign pslverr   = acc && !offset_ok;

	// ------------------------------
	// Divider register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div <= periph_pkg::UART_DIV_RESET;
		end else if (acc && pwrite && paddr.fields.offset == periph_pkg::UART_DIV) begin
			div <= pwdata[periph_pkg::UART_DIV_W-1:0];
		end
	end

	// ------------------------------
	// Frame shifter

	// Frame is stop, data, start; bit 0 drives the line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			bit_ctr <= '0;
			bit_idx <= '0;
			shreg   <= '1;
		end else if (tx_accept) begin
			busy    <= 1'b1;
			bit_ctr <= div - 1'b1;
			bit_idx <= '0;
			shreg   <= {1'b1, pwdata[7:0], 1'b0};
		end else if (bit_end) begin
			bit_ctr <= div - 1'b1;
			bit_idx <= bit_idx + 1'b1;
			// Shifting in ones leaves the line idle once the stop bit is out
			shreg   <= {1'b1, shreg[periph_pkg::UART_FRAME_BITS-1:1]};
			if (frame_end) begin
				busy <= 1'b0;
			end
		end else if (busy) begin
			bit_ctr <= bit_ctr - 1'b1;
		end
	end

	assign tx = shreg[0];

	// ------------------------------
	// Read data, zero outside a read access

	always_comb begin
		prdata = '0;
		if (acc && !pwrite) begin
			case (paddr.fields.offset)
				periph_pkg::UART_STATUS: prdata[0] = busy;
				periph_pkg::UART_DIV:    prdata[periph_pkg::UART_DIV_W-1:0] = div;
				// TXDATA is write only and reads as zero
				default: ;
			endcase
		end
	end

endmodule
